// File: dma_pkg.sv
`default_nettype none

package dma_pkg;

  localparam int DATA_W       = 32;  // host data and register width
  localparam int ADDR_W       = 32;  // descriptor address
  localparam int LEN_W        = 32;  // descriptor length, bytes per transfer
  localparam int TAG_W        = 8;   // output descriptor tag
  localparam int CNT_W        = 32;  // transfer, pass and bundle loops
  localparam int BUNDLE_WORDS = 8;   // words per record, last one is padding
  localparam int REG_SPACE    = 16;  // bundle table starts at this host address

  typedef enum logic [3:0] {
    REG_START        = 4'd0,
    REG_DONE_READ0   = 4'd1,   // host has drained bank 0
    REG_DONE_READ1   = 4'd2,
    REG_DONE_WRITE0  = 4'd3,   // output DMA has filled bank 0
    REG_DONE_WRITE1  = 4'd4,
    REG_OCM_BASE0    = 4'd5,
    REG_OCM_BASE1    = 4'd6,
    REG_WEIGHTS_BASE = 4'd7,
    REG_BUNDLE_DONE  = 4'd8,   // host lets the pixel side start the next bundle
    REG_N_BUNDLES    = 4'd9,
    REG_W_DONE       = 4'd10,  // debug, weight side idle
    REG_X_DONE       = 4'd11,  // debug, pixel side idle
    REG_O_DONE       = 4'd12   // debug, output side drained
  } reg_addr_e;

  // members run from the top word down, so x_base sits in word 0
  typedef struct packed {
    logic [CNT_W-1:0]  max_t;     // word 6
    logic [CNT_W-1:0]  max_p;     // word 5
    logic [LEN_W-1:0]  w_bpt;     // word 4
    logic [LEN_W-1:0]  w_bpt_p0;  // word 3
    logic [LEN_W-1:0]  x_bpt;     // word 2
    logic [LEN_W-1:0]  x_bpt_p0;  // word 1
    logic [ADDR_W-1:0] x_base;    // word 0
  } bundle_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } desc_t;

  typedef struct packed {
    desc_t             desc;
    logic [TAG_W-1:0]  tag;  // bank index
  } out_desc_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;    // bank the DMA just finished
    logic [3:0]       error;  // zero means good
    logic             valid;
  } os_status_t;

  typedef struct packed {
    logic             valid;
    logic             ready;
    logic             last;
    logic [LEN_W-1:0] bpt;  // size of the packet being streamed
  } eng_stream_t;

  typedef enum logic [1:0] {
    W_IDLE,
    W_WAIT_RAM,
    W_EXEC
  } w_state_e;

  typedef enum logic [1:0] {
    X_IDLE,
    X_WAIT_RAM,
    X_WAIT_BUNDLE,
    X_EXEC
  } x_state_e;

endpackage

`default_nettype wire

// File: dma_counter.sv
`timescale 1ns/100ps
`default_nettype none

module dma_counter (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      i_load,
  input  logic                      i_en,
  input  logic [dma_pkg::CNT_W-1:0] i_max,
  output logic [dma_pkg::CNT_W-1:0] o_count,
  output logic                      o_first,
  output logic                      o_last,
  output logic                      o_last_clk
);
  import dma_pkg::*;

  logic [CNT_W-1:0] max_q;  // reload value kept for wrap around

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_count <= '0;
      max_q   <= '0;
    end else if (i_load) begin
      o_count <= i_max;
      max_q   <= i_max;
    end else if (i_en) begin
      o_count <= o_last ? max_q : o_count - CNT_W'(1);  // wrap so the loop can rerun
    end
  end

  assign o_last     = (o_count == '0);
  assign o_first    = (o_count == max_q);
  assign o_last_clk = o_last && i_en;  // end of loop, steps the next counter

endmodule

`default_nettype wire

// File: bundle_ram.sv
`timescale 1ns/100ps
`default_nettype none

module bundle_ram #(
  parameter  int BUNDLE_DEPTH = 16,
  localparam int IDX_W        = $clog2(BUNDLE_DEPTH)
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       i_wr_en,
  input  logic [dma_pkg::ADDR_W-1:0] i_wr_addr,
  input  logic [dma_pkg::DATA_W-1:0] i_wr_data,
  input  logic                       i_w_req,
  input  logic [IDX_W-1:0]           i_w_idx,
  input  logic                       i_x_req,
  input  logic [IDX_W-1:0]           i_x_idx,
  output dma_pkg::bundle_t           o_bundle,
  output logic                       o_w_valid,
  output logic                       o_x_valid
);
  import dma_pkg::*;

  localparam int WORD_W    = $clog2(BUNDLE_WORDS);
  localparam int REC_WORDS = $bits(bundle_t) / DATA_W;  // padding word never read

  logic [DATA_W-1:0] mem [BUNDLE_DEPTH][BUNDLE_WORDS];
  logic [ADDR_W-1:0] tbl_addr;  // word offset into the table
  logic              tbl_wr;
  logic [IDX_W-1:0]  rd_idx;

  assign tbl_wr   = i_wr_en && (i_wr_addr >= ADDR_W'(REG_SPACE));
  assign tbl_addr = i_wr_addr - ADDR_W'(REG_SPACE);
  assign rd_idx   = i_x_req ? i_x_idx : i_w_idx;  // pixel side wins

  always_ff @(posedge clk) begin
    if (tbl_wr) begin
      mem[tbl_addr[WORD_W +: IDX_W]][tbl_addr[WORD_W-1:0]] <= i_wr_data;
    end
    if (i_x_req || i_w_req) begin
      for (int k = 0; k < REC_WORDS; k++) begin
        o_bundle[k*DATA_W +: DATA_W] <= mem[rd_idx][k];  // whole record in one read
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_x_valid <= 1'b0;
      o_w_valid <= 1'b0;
    end else begin
      o_x_valid <= i_x_req;
      o_w_valid <= i_w_req && !i_x_req;  // loser keeps requesting
    end
  end

  // a weight request that loses to the pixel side comes back next cycle
  a_w_retry: assert property (@(posedge clk) disable iff (!rstn)
    i_w_req && i_x_req |=> i_w_req);

endmodule

`default_nettype wire

// File: dma_regs.sv
`timescale 1ns/100ps
`default_nettype none

module dma_regs (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            i_wr_en,
  input  logic [dma_pkg::ADDR_W-1:0]      i_wr_addr,
  input  logic [dma_pkg::DATA_W-1:0]      i_wr_data,
  input  logic                            i_rd_en,
  input  logic [dma_pkg::ADDR_W-1:0]      i_rd_addr,
  output logic [dma_pkg::DATA_W-1:0]      o_rd_data,
  input  dma_pkg::os_status_t             i_os,
  input  dma_pkg::eng_stream_t            i_eng,
  input  logic                            i_bank_take,
  input  logic                            i_bank_idx,
  input  logic                            i_pkt_open,
  input  logic                            i_w_idle,
  input  logic                            i_x_idle,
  input  logic                            i_bundle_taken,
  output logic                            o_start,
  output logic [dma_pkg::ADDR_W-1:0]      o_weights_base,
  output logic [dma_pkg::CNT_W-1:0]       o_n_bundles,
  output logic                            o_bundle_done,
  output logic [1:0][dma_pkg::ADDR_W-1:0] o_ocm_base,
  output logic [1:0]                      o_done_read
);
  import dma_pkg::*;

  localparam int NREGS = int'(REG_O_DONE) + 1;

  logic [NREGS-1:0][DATA_W-1:0] regs;
  logic                         os_good;
  logic                         wr_reg;  // host write into register space
  logic                         rd_reg;

  assign os_good = i_os.valid && (i_os.error == '0);
  assign wr_reg  = i_wr_en && (i_wr_addr < ADDR_W'(NREGS));  // table writes fall away here
  assign rd_reg  = i_rd_addr < ADDR_W'(NREGS);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      regs                  <= '0;
      regs[REG_DONE_READ0]  <= DATA_W'(1);  // both banks free at start
      regs[REG_DONE_READ1]  <= DATA_W'(1);
      regs[REG_BUNDLE_DONE] <= DATA_W'(1);  // first bundle needs no handshake
    end else begin
      if (regs[REG_START][0]) begin
        regs[REG_START] <= '0;  // one cycle pulse
      end
      if (i_bundle_taken) begin
        regs[REG_BUNDLE_DONE] <= '0;
      end
      if (i_bank_take) begin  // output side moves into this bank
        regs[REG_DONE_READ0 + i_bank_idx]  <= '0;
        regs[REG_DONE_WRITE0 + i_bank_idx] <= '0;
      end
      if (os_good) begin
        regs[REG_DONE_WRITE0 + i_os.tag[0]] <= DATA_W'(1);
      end
      regs[REG_W_DONE] <= DATA_W'(i_w_idle);
      regs[REG_X_DONE] <= DATA_W'(i_x_idle);
      if (regs[REG_START][0] || i_eng.valid) begin
        regs[REG_O_DONE] <= '0;  // engine still has data
      end else if (os_good && !i_pkt_open) begin
        regs[REG_O_DONE] <= DATA_W'(1);
      end
      if (wr_reg) begin
        regs[i_wr_addr[3:0]] <= i_wr_data;  // host has the last word
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_rd_data <= '0;
    end else if (i_rd_en) begin
      o_rd_data <= rd_reg ? regs[i_rd_addr[3:0]] : '0;  // held until next read
    end
  end

  assign o_start        = regs[REG_START][0];
  assign o_weights_base = regs[REG_WEIGHTS_BASE];
  assign o_n_bundles    = regs[REG_N_BUNDLES];
  assign o_bundle_done  = regs[REG_BUNDLE_DONE][0];
  assign o_ocm_base     = {regs[REG_OCM_BASE1], regs[REG_OCM_BASE0]};
  assign o_done_read    = {regs[REG_DONE_READ1][0], regs[REG_DONE_READ0][0]};

  // both generators sample start as a single event per run
  a_start_pulse: assert property (@(posedge clk) disable iff (!rstn)
    o_start |=> !o_start);

endmodule

`default_nettype wire

// File: weight_desc_gen.sv
`timescale 1ns/100ps
`default_nettype none

module weight_desc_gen #(
  parameter  int BUNDLE_DEPTH = 16,
  localparam int IDX_W        = $clog2(BUNDLE_DEPTH)
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       i_start,
  input  logic [dma_pkg::ADDR_W-1:0] i_weights_base,
  input  logic [dma_pkg::CNT_W-1:0]  i_n_bundles,
  input  dma_pkg::bundle_t           i_bundle,
  input  logic                       i_valid,
  output logic                       o_req,
  output logic [IDX_W-1:0]           o_idx,
  output dma_pkg::desc_t             o_desc,
  output logic                       o_valid,
  input  logic                       i_ready,
  output logic                       o_idle
);
  import dma_pkg::*;

  w_state_e         state, state_nxt;
  logic             fire, lc_t, lc_p, lc_b, first_p;
  logic [CNT_W-1:0] b_count;
  logic [LEN_W-1:0] bpt_p0, bpt;  // lengths of the loaded bundle

  always_comb begin
    state_nxt = state;
    unique case (state)
      W_IDLE:     if (i_start) state_nxt = W_WAIT_RAM;
      W_WAIT_RAM: if (i_valid) state_nxt = W_EXEC;
      W_EXEC:     if (lc_b) state_nxt = W_IDLE;  // all bundles issued
                  else if (lc_p) state_nxt = W_WAIT_RAM;  // fetch next record
      default:    state_nxt = W_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= W_IDLE;
      o_desc.addr <= '0;
    end else begin
      state <= state_nxt;
      if (i_start) begin
        o_desc.addr <= i_weights_base;
      end else if (fire) begin
        o_desc.addr <= o_desc.addr + ADDR_W'(o_desc.len);  // linear across bundles
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      bpt_p0 <= i_bundle.w_bpt_p0;
      bpt    <= i_bundle.w_bpt;
    end
  end

  assign o_req      = (state == W_WAIT_RAM) && !i_valid;  // held while arbitration loses
  assign o_idx      = IDX_W'(i_n_bundles - CNT_W'(1) - b_count);  // counts up from 0
  assign o_desc.len = first_p ? bpt_p0 : bpt;
  assign o_valid    = (state == W_EXEC);
  assign o_idle     = (state == W_IDLE);
  assign fire       = o_valid && i_ready;

  dma_counter u_cnt_t (
    .clk(clk), .rstn(rstn), .i_load(i_valid), .i_en(fire),
    .i_max(i_bundle.max_t - CNT_W'(1)),
    .o_count(), .o_first(), .o_last(), .o_last_clk(lc_t)
  );

  dma_counter u_cnt_p (
    .clk(clk), .rstn(rstn), .i_load(i_valid), .i_en(lc_t),
    .i_max(i_bundle.max_p - CNT_W'(1)),
    .o_count(), .o_first(first_p), .o_last(), .o_last_clk(lc_p)
  );

  dma_counter u_cnt_b (
    .clk(clk), .rstn(rstn), .i_load(i_start), .i_en(lc_p),
    .i_max(i_n_bundles - CNT_W'(1)),
    .o_count(b_count), .o_first(), .o_last(), .o_last_clk(lc_b)
  );

  a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_valid && !i_ready |=> o_valid && $stable(o_desc));

endmodule

`default_nettype wire

// File: pixel_desc_gen.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_desc_gen #(
  parameter  int BUNDLE_DEPTH = 16,
  localparam int IDX_W        = $clog2(BUNDLE_DEPTH)
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      i_start,
  input  logic [dma_pkg::CNT_W-1:0] i_n_bundles,
  input  dma_pkg::bundle_t          i_bundle,
  input  logic                      i_valid,
  input  logic                      i_bundle_done,
  output logic                      o_bundle_taken,
  output logic                      o_req,
  output logic [IDX_W-1:0]          o_idx,
  output dma_pkg::desc_t            o_desc,
  output logic                      o_valid,
  input  logic                      i_ready,
  output logic                      o_idle
);
  import dma_pkg::*;

  x_state_e         state, state_nxt;
  logic             fire, lc_t, lc_p, lc_b, first_p;
  logic [CNT_W-1:0] b_count;
  logic [LEN_W-1:0] bpt_p0, bpt;

  always_comb begin
    state_nxt = state;
    unique case (state)
      X_IDLE:        if (i_start) state_nxt = X_WAIT_RAM;
      X_WAIT_RAM:    if (i_valid) state_nxt = X_WAIT_BUNDLE;
      X_WAIT_BUNDLE: if (i_bundle_done) state_nxt = X_EXEC;  // host released the bundle
      X_EXEC:        if (lc_b) state_nxt = X_IDLE;
                     else if (lc_p) state_nxt = X_WAIT_RAM;
      default:       state_nxt = X_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state       <= X_IDLE;
      o_desc.addr <= '0;
    end else begin
      state <= state_nxt;
      if (i_valid) begin
        o_desc.addr <= i_bundle.x_base;  // each bundle has its own base
      end else if (lc_t) begin
        o_desc.addr <= o_desc.addr + ADDR_W'(o_desc.len);  // step once per pass
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      bpt_p0 <= i_bundle.x_bpt_p0;
      bpt    <= i_bundle.x_bpt;
    end
  end

  assign o_req          = (state == X_WAIT_RAM) && !i_valid;
  assign o_idx          = IDX_W'(i_n_bundles - CNT_W'(1) - b_count);
  assign o_bundle_taken = (state == X_WAIT_BUNDLE) && i_bundle_done;  // clears the flag
  assign o_desc.len     = first_p ? bpt_p0 : bpt;
  assign o_valid        = (state == X_EXEC);
  assign o_idle         = (state == X_IDLE);
  assign fire           = o_valid && i_ready;

  dma_counter u_cnt_t (
    .clk(clk), .rstn(rstn), .i_load(i_valid), .i_en(fire),
    .i_max(i_bundle.max_t - CNT_W'(1)),
    .o_count(), .o_first(), .o_last(), .o_last_clk(lc_t)
  );

  dma_counter u_cnt_p (
    .clk(clk), .rstn(rstn), .i_load(i_valid), .i_en(lc_t),
    .i_max(i_bundle.max_p - CNT_W'(1)),
    .o_count(), .o_first(first_p), .o_last(), .o_last_clk(lc_p)
  );

  dma_counter u_cnt_b (
    .clk(clk), .rstn(rstn), .i_load(i_start), .i_en(lc_p),
    .i_max(i_n_bundles - CNT_W'(1)),
    .o_count(b_count), .o_first(), .o_last(), .o_last_clk(lc_b)
  );

  a_x_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_valid && !i_ready |=> o_valid && $stable(o_desc));

endmodule

`default_nettype wire

// File: out_desc_gen.sv
`timescale 1ns/100ps
`default_nettype none

module out_desc_gen (
  input  logic                            clk,
  input  logic                            rstn,
  input  dma_pkg::eng_stream_t            i_eng,
  input  logic [1:0]                      i_done_read,
  input  logic [1:0][dma_pkg::ADDR_W-1:0] i_ocm_base,
  output dma_pkg::out_desc_t              o_desc,
  output logic                            o_valid,
  input  logic                            i_ready,
  output logic                            o_bank_take,
  output logic                            o_bank_idx,
  output logic                            o_pkt_open
);
  import dma_pkg::*;

  logic bank;      // bank the DMA is writing now
  logic bank_nxt;
  logic got_last;  // stream bpt belongs to a new packet
  logic take;

  assign bank_nxt = ~bank;
  assign take     = i_ready && i_eng.valid && got_last && i_done_read[bank_nxt];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bank     <= 1'b1;  // first issue lands in bank 0
      got_last <= 1'b1;
      o_valid  <= 1'b0;
    end else begin
      if (i_eng.valid && i_eng.ready && i_eng.last) begin
        got_last <= 1'b1;
      end
      if (take) begin
        bank     <= bank_nxt;
        got_last <= 1'b0;
        o_valid  <= 1'b1;
      end else if (o_valid && i_ready) begin
        o_valid  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin  // payload latched with the decision
      o_desc.desc.addr <= i_ocm_base[bank_nxt];
      o_desc.desc.len  <= i_eng.bpt;
      o_desc.tag       <= TAG_W'(bank_nxt);
    end
  end

  assign o_bank_take = take;
  assign o_bank_idx  = bank_nxt;
  assign o_pkt_open  = !got_last;

endmodule

`default_nettype wire

// File: dma_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl_top #(
  parameter int BUNDLE_DEPTH = 16
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       i_wr_en,
  input  logic [dma_pkg::ADDR_W-1:0] i_wr_addr,
  input  logic [dma_pkg::DATA_W-1:0] i_wr_data,
  input  logic                       i_rd_en,
  input  logic [dma_pkg::ADDR_W-1:0] i_rd_addr,
  output logic [dma_pkg::DATA_W-1:0] o_rd_data,
  input  dma_pkg::eng_stream_t       i_eng,
  input  dma_pkg::os_status_t        i_os,
  output dma_pkg::desc_t             o_wd,
  output logic                       o_wd_valid,
  input  logic                       i_wd_ready,
  output dma_pkg::desc_t             o_xd,
  output logic                       o_xd_valid,
  input  logic                       i_xd_ready,
  output dma_pkg::out_desc_t         o_od,
  output logic                       o_od_valid,
  input  logic                       i_od_ready
);
  import dma_pkg::*;

  localparam int IDX_W = $clog2(BUNDLE_DEPTH);

  logic                   start, bundle_done, bundle_taken;
  logic [ADDR_W-1:0]      weights_base;
  logic [CNT_W-1:0]       n_bundles;
  logic [1:0][ADDR_W-1:0] ocm_base;
  logic [1:0]             done_read;
  logic                   bank_take, bank_idx, pkt_open;
  logic                   w_idle, x_idle;
  bundle_t                bundle;
  logic                   w_req, x_req, w_valid, x_valid;
  logic [IDX_W-1:0]       w_idx, x_idx;

  dma_regs u_regs (
    .clk(clk), .rstn(rstn),
    .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
    .i_rd_en(i_rd_en), .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
    .i_os(i_os), .i_eng(i_eng),
    .i_bank_take(bank_take), .i_bank_idx(bank_idx), .i_pkt_open(pkt_open),
    .i_w_idle(w_idle), .i_x_idle(x_idle), .i_bundle_taken(bundle_taken),
    .o_start(start), .o_weights_base(weights_base), .o_n_bundles(n_bundles),
    .o_bundle_done(bundle_done), .o_ocm_base(ocm_base), .o_done_read(done_read)
  );

  bundle_ram #(.BUNDLE_DEPTH(BUNDLE_DEPTH)) u_ram (
    .clk(clk), .rstn(rstn),
    .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
    .i_w_req(w_req), .i_w_idx(w_idx), .i_x_req(x_req), .i_x_idx(x_idx),
    .o_bundle(bundle), .o_w_valid(w_valid), .o_x_valid(x_valid)
  );

  weight_desc_gen #(.BUNDLE_DEPTH(BUNDLE_DEPTH)) u_wgen (
    .clk(clk), .rstn(rstn),
    .i_start(start), .i_weights_base(weights_base), .i_n_bundles(n_bundles),
    .i_bundle(bundle), .i_valid(w_valid), .o_req(w_req), .o_idx(w_idx),
    .o_desc(o_wd), .o_valid(o_wd_valid), .i_ready(i_wd_ready), .o_idle(w_idle)
  );

  pixel_desc_gen #(.BUNDLE_DEPTH(BUNDLE_DEPTH)) u_xgen (
    .clk(clk), .rstn(rstn),
    .i_start(start), .i_n_bundles(n_bundles),
    .i_bundle(bundle), .i_valid(x_valid),
    .i_bundle_done(bundle_done), .o_bundle_taken(bundle_taken),
    .o_req(x_req), .o_idx(x_idx),
    .o_desc(o_xd), .o_valid(o_xd_valid), .i_ready(i_xd_ready), .o_idle(x_idle)
  );

  out_desc_gen u_ogen (
    .clk(clk), .rstn(rstn),
    .i_eng(i_eng), .i_done_read(done_read), .i_ocm_base(ocm_base),
    .o_desc(o_od), .o_valid(o_od_valid), .i_ready(i_od_ready),
    .o_bank_take(bank_take), .o_bank_idx(bank_idx), .o_pkt_open(pkt_open)
  );

endmodule

`default_nettype wire

// File: tb_dma_model.svh
`ifndef TB_DMA_MODEL_SVH
`define TB_DMA_MODEL_SVH

// random table and stream as the host programs them
bundle_t                tbl [16];
int                     n_bund;
logic [ADDR_W-1:0]      w_base;
logic [1:0][ADDR_W-1:0] ocm;           // one base per result bank
logic [LEN_W-1:0]       pkt_bpt [$];   // bytes per transfer of each engine packet

// predicted handshakes, popped by the sinks in order
desc_t     exp_w [$];
desc_t     exp_x [$];
int        exp_xb [$];   // bundle that each pixel descriptor belongs to
int        x_cum [16];   // pixel descriptors up to and including bundle b
out_desc_t exp_o [$];
int        total_xfer;

function automatic logic [LEN_W-1:0] pass_len(input logic [LEN_W-1:0] p0,
                                              input logic [LEN_W-1:0] rest, input int p);
  return (p == 0) ? p0 : rest;  // pass 0 has its own size
endfunction

task automatic build_expected();
  logic [ADDR_W-1:0] wa;
  logic [ADDR_W-1:0] xa;
  desc_t             d;
  out_desc_t         od;
  wa         = w_base;  // weight address runs on across bundles
  total_xfer = 0;
  for (int b = 0; b < n_bund; b++) begin
    xa = tbl[b].x_base;
    for (int p = 0; p < int'(tbl[b].max_p); p++) begin
      for (int t = 0; t < int'(tbl[b].max_t); t++) begin
        d.addr = wa;
        d.len  = pass_len(tbl[b].w_bpt_p0, tbl[b].w_bpt, p);
        exp_w.push_back(d);
        wa     = wa + d.len;
        d.addr = xa;  // same pixel address for the whole pass
        d.len  = pass_len(tbl[b].x_bpt_p0, tbl[b].x_bpt, p);
        exp_x.push_back(d);
        exp_xb.push_back(b);
        total_xfer++;
      end
      xa = xa + pass_len(tbl[b].x_bpt_p0, tbl[b].x_bpt, p);  // step once per pass
    end
    x_cum[b] = total_xfer;
  end
  for (int k = 0; k < pkt_bpt.size(); k++) begin
    od.desc.addr = ocm[k % 2];  // ping-pong starting at bank 0
    od.desc.len  = pkt_bpt[k];
    od.tag       = TAG_W'(k % 2);
    exp_o.push_back(od);
  end
endtask

`endif

// File: tb_dma_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dma_ctrl;
  import dma_pkg::*;

  localparam int          DEPTH  = 16;
  localparam logic [31:0] SEED   = 32'h105dbd11;
  localparam int          MARGIN = 4;  // slack on the cycle estimate

  logic              clk, rstn;
  logic              i_wr_en, i_rd_en;
  logic [ADDR_W-1:0] i_wr_addr, i_rd_addr;
  logic [DATA_W-1:0] i_wr_data, o_rd_data;
  eng_stream_t       i_eng;
  os_status_t        i_os;
  desc_t             o_wd, o_xd;
  out_desc_t         o_od;
  logic              o_wd_valid, o_xd_valid, o_od_valid;
  logic              i_wd_ready, i_xd_ready, i_od_ready;

  int         errors, checks, limit_cyc, n_pkt;
  int         released;   // bundles the host has let through
  int         x_got;      // pixel descriptors taken so far
  bit         host_busy;  // one user of the host port at a time
  logic [1:0] bank_free;  // shadow of done_read
  int         st_tag [$];  // finished banks waiting for the host
  int         st_err [$];

  `include "tb_dma_model.svh"

  dma_ctrl_top #(.BUNDLE_DEPTH(DEPTH)) dut0 (
    .clk(clk), .rstn(rstn),
    .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
    .i_rd_en(i_rd_en), .i_rd_addr(i_rd_addr), .o_rd_data(o_rd_data),
    .i_eng(i_eng), .i_os(i_os),
    .o_wd(o_wd), .o_wd_valid(o_wd_valid), .i_wd_ready(i_wd_ready),
    .o_xd(o_xd), .o_xd_valid(o_xd_valid), .i_xd_ready(i_xd_ready),
    .o_od(o_od), .o_od_valid(o_od_valid), .i_od_ready(i_od_ready)
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic compare(input string name, input logic [79:0] exp, input logic [79:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    while (host_busy) @(posedge clk);
    host_busy = 1'b1;
    @(posedge clk);
    i_wr_en   <= 1'b1;  // one cycle strobe
    i_wr_addr <= addr;
    i_wr_data <= data;
    @(posedge clk);
    i_wr_en   <= 1'b0;
    host_busy = 1'b0;
  endtask

  task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    while (host_busy) @(posedge clk);
    host_busy = 1'b1;
    @(posedge clk);
    i_rd_en   <= 1'b1;
    i_rd_addr <= addr;
    @(posedge clk);
    i_rd_en   <= 1'b0;
    @(negedge clk);
    data      = o_rd_data;  // valid one cycle after the strobe
    host_busy = 1'b0;
  endtask

  task automatic weight_sink();
    while (exp_w.size() > 0) begin
      @(posedge clk);
      i_wd_ready <= 1'($urandom % 3 != 0);
      @(negedge clk);
      if (o_wd_valid && i_wd_ready) begin  // transfer at the coming edge
        compare("weight_desc", exp_w[0], o_wd);
        void'(exp_w.pop_front());
      end
    end
    @(posedge clk);
    i_wd_ready <= 1'b0;
  endtask

  task automatic pixel_sink();
    while (exp_x.size() > 0) begin
      @(posedge clk);
      i_xd_ready <= 1'($urandom % 2);
      @(negedge clk);
      if (o_xd_valid && i_xd_ready) begin
        compare("pixel_released", 1, released > exp_xb[0]);  // no issue before bundle_done
        compare("pixel_desc", exp_x[0], o_xd);
        void'(exp_x.pop_front());
        void'(exp_xb.pop_front());
        x_got++;
      end
    end
    @(posedge clk);
    i_xd_ready <= 1'b0;
  endtask

  task automatic release_bundles();
    logic [DATA_W-1:0] rd;
    for (int b = 1; b < n_bund; b++) begin
      while (x_got < x_cum[b-1]) @(posedge clk);  // previous bundle fully issued
      repeat ($urandom % 16) @(posedge clk);
      host_read(ADDR_W'(REG_BUNDLE_DONE), rd);
      compare("bundle_done_taken", 0, rd);
      host_write(ADDR_W'(REG_BUNDLE_DONE), 1);
      released = b + 1;
    end
  endtask

  task automatic stream_packets();
    logic [DATA_W-1:0] rd;
    out_desc_t         od;
    int                beats, sent;
    bit                taken;
    logic [3:0]        err;
    for (int k = 0; k < n_pkt; k++) begin
      @(posedge clk);
      i_eng <= '{valid: 1'b1, ready: 1'b0, last: 1'b0, bpt: pkt_bpt[k]};  // beats held back
      taken = 1'b0;
      while (!taken) begin
        @(posedge clk);
        i_od_ready <= 1'($urandom % 2);
        @(negedge clk);
        if (o_od_valid && i_od_ready) begin
          od = exp_o.pop_front();
          compare("out_bank_free", 1, bank_free[od.tag[0]]);
          compare("out_desc", od, o_od);
          bank_free[od.tag[0]] = 1'b0;
          taken = 1'b1;
        end
      end
      @(posedge clk);
      i_od_ready <= 1'b0;
      host_read(ADDR_W'(REG_O_DONE), rd);  // stream still valid here
      compare("o_done_busy", 0, rd);
      beats = 1 + $urandom % 4;
      sent  = 0;
      while (sent < beats) begin
        @(posedge clk);
        i_eng.ready <= 1'($urandom % 2);
        i_eng.last  <= (sent == beats - 1);
        @(negedge clk);
        if (i_eng.ready) sent++;
      end
      err = (k == 1) ? 4'(1 + $urandom % 15) : 4'd0;  // one bank write fails
      @(posedge clk);
      i_eng <= '0;
      i_os  <= '{tag: od.tag, error: err, valid: 1'b1};
      @(posedge clk);
      i_os <= '0;
      st_tag.push_back(int'(od.tag));
      st_err.push_back(int'(err));
    end
  endtask

  task automatic drain_banks();
    logic [DATA_W-1:0] rd;
    int                tag, err;
    for (int k = 0; k < n_pkt; k++) begin
      while (st_tag.size() == 0) @(posedge clk);
      tag = st_tag.pop_front();
      err = st_err.pop_front();
      repeat ($urandom % 24) @(posedge clk);  // host busy with the bank
      host_read(ADDR_W'(REG_DONE_WRITE0) + ADDR_W'(tag), rd);
      compare("done_write", (err == 0), rd);
      host_write(ADDR_W'(REG_DONE_READ0) + ADDR_W'(tag), 1);
      bank_free[tag] = 1'b1;
    end
  endtask

  initial begin
    wait (limit_cyc > 0);
    repeat (limit_cyc) @(posedge clk);
    $display("watchdog: run still busy after %0d cycles", limit_cyc);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    logic [DATA_W-1:0] rd, wr;
    logic [ADDR_W-1:0] ra;
    bundle_t           bnd;
    void'($urandom(SEED));
    clk        = 1'b0;
    rstn       = 1'b0;
    i_wr_en    = 1'b0;
    i_wr_addr  = '0;
    i_wr_data  = '0;
    i_rd_en    = 1'b0;
    i_rd_addr  = '0;
    i_eng      = '0;
    i_os       = '0;
    i_wd_ready = 1'b0;
    i_xd_ready = 1'b0;
    i_od_ready = 1'b0;
    host_busy  = 1'b0;
    bank_free  = 2'b11;
    released   = 1;  // bundle_done is set for bundle 0
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    host_read(ADDR_W'(REG_DONE_READ0), rd);
    compare("reset_done_read0", 1, rd);
    host_read(ADDR_W'(REG_DONE_READ1), rd);
    compare("reset_done_read1", 1, rd);
    repeat (12) begin  // start and the debug flags stay out of this
      ra = ADDR_W'(1 + $urandom % 9);
      wr = $urandom;
      host_write(ra, wr);
      host_read(ra, rd);
      compare("readback", wr, rd);
    end
    n_bund = 2 + $urandom % 3;
    w_base = $urandom & 32'hffff_fff0;
    ocm[0] = $urandom & 32'hffff_f000;
    ocm[1] = $urandom & 32'hffff_f000;
    for (int b = 0; b < n_bund; b++) begin
      bnd.x_base   = $urandom & 32'hffff_ff00;
      bnd.x_bpt_p0 = LEN_W'(($urandom % 32 + 1) * 8);
      bnd.x_bpt    = LEN_W'(($urandom % 32 + 1) * 8);
      bnd.w_bpt_p0 = LEN_W'(($urandom % 32 + 1) * 16);
      bnd.w_bpt    = LEN_W'(($urandom % 32 + 1) * 16);
      bnd.max_p    = CNT_W'(1 + $urandom % 3);
      bnd.max_t    = CNT_W'(1 + $urandom % 3);
      tbl[b]       = bnd;
      for (int w = 0; w < 7; w++) begin
        host_write(ADDR_W'(REG_SPACE + b * BUNDLE_WORDS + w), bnd[w*DATA_W +: DATA_W]);
      end
    end
    n_pkt = 4 + $urandom % 3;
    for (int k = 0; k < n_pkt; k++) pkt_bpt.push_back(LEN_W'(($urandom % 64 + 1) * 4));
    host_write(ADDR_W'(REG_WEIGHTS_BASE), w_base);
    host_write(ADDR_W'(REG_OCM_BASE0), ocm[0]);
    host_write(ADDR_W'(REG_OCM_BASE1), ocm[1]);
    host_write(ADDR_W'(REG_N_BUNDLES), DATA_W'(n_bund));
    host_write(ADDR_W'(REG_DONE_READ0), 1);
    host_write(ADDR_W'(REG_DONE_READ1), 1);
    host_write(ADDR_W'(REG_BUNDLE_DONE), 1);
    build_expected();
    limit_cyc = MARGIN * (8 * total_xfer + 60 * n_pkt + 40 * n_bund + 200);
    host_write(ADDR_W'(REG_START), 1);
    fork
      weight_sink();
      pixel_sink();
      release_bundles();
      stream_packets();
      drain_banks();
    join
    host_read(ADDR_W'(REG_W_DONE), rd);
    compare("w_done", 1, rd);
    host_read(ADDR_W'(REG_X_DONE), rd);
    compare("x_done", 1, rd);
    host_read(ADDR_W'(REG_BUNDLE_DONE), rd);
    compare("bundle_done_end", 0, rd);
    host_read(ADDR_W'(REG_O_DONE), rd);
    compare("o_done", 1, rd);  // last packet ended with a good status
    compare("w_valid_end", 0, o_wd_valid);
    compare("x_valid_end", 0, o_xd_valid);
    compare("o_valid_end", 0, o_od_valid);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
dma_pkg.sv
dma_counter.sv
bundle_ram.sv
dma_regs.sv
weight_desc_gen.sv
pixel_desc_gen.sv
out_desc_gen.sv
dma_ctrl_top.sv
tb_dma_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_dma_ctrl -o sim_dma_ctrl
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_dma_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
fi
exit 1
